// ==== hdl/ahb_pkg.sv ====
//------------------------------------------------
// AHB-Lite protocol types used by the decoder stage
// Only OKAY and ERROR are ever driven as responses
// Decode covers HADDR[31:10] only
//------------------------------------------------

package ahb_pkg;

    // Transfer type, HTRANS encoding
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // Slave response, HRESP encoding
    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01,
        RETRY = 2'b10,   // Never produced here
        SPLIT = 2'b11    // Never produced here
    } hresp_t;

    localparam int DATA_W       = 32;                 // Read data width
    localparam int DEC_ADDR_LSB = 10;                 // Lowest decoded HADDR bit
    localparam int DEC_ADDR_W   = 32 - DEC_ADDR_LSB;  // HADDR[31:10], 22 bits

    typedef logic [DEC_ADDR_W-1:0] dec_addr_t;  // Decoded address slice
    typedef logic [DATA_W-1:0]     hrdata_t;    // Read data word

endpackage

// ==== hdl/matrix_pkg.sv ====
//------------------------------------------------
// Output port map of this matrix input
// Bounds are in 1 KB units of HADDR[31:10], inclusive
// Regions must not overlap, MI0 has highest priority
//------------------------------------------------

package matrix_pkg;

    import ahb_pkg::*;

    // Owner of a transfer, four real ports plus local default slave
    typedef enum logic [2:0] {
        PORT_MI0,
        PORT_MI1,
        PORT_MI2,
        PORT_MI3,
        PORT_DFT
    } out_port_t;

    localparam int NUM_PORTS = 4;   // Real output ports

    //------------------------------------------------
    // Region bounds per port
    //------------------------------------------------
    localparam dec_addr_t REGION_LO [NUM_PORTS] = '{
        22'h000000,   // MI0 0x00000000
        22'h080000,   // MI1 0x20000000
        22'h100000,   // MI2 0x40000000
        22'h100040    // MI3 0x40010000
    };

    localparam dec_addr_t REGION_HI [NUM_PORTS] = '{
        22'h0003ff,   // MI0 0x000FFFFF
        22'h0803ff,   // MI1 0x200FFFFF
        22'h100017,   // MI2 0x40005FFF
        22'h100043    // MI3 0x40010FFF
    };

    // Port index to port code
    function automatic out_port_t port_of(input int unsigned idx);
        return out_port_t'(idx[2:0]);
    endfunction

endpackage

// ==== hdl/dft_slave_if.sv ====
//------------------------------------------------
// Link to the local default slave
// htrans and hready come from the stage top level
//------------------------------------------------
`timescale 1ns/100ps

interface dft_slave_if
    import ahb_pkg::*;
();

    logic    hsel;        // Address phase select from decoder
    htrans_t htrans;      // Transfer type of the input port
    logic    hready;      // Transfer done on the input port
    logic    hreadyout;   // Default slave ready
    hresp_t  hresp;       // Default slave response

    modport decoder (output hsel);

    modport slave (
        input  hsel, htrans, hready,
        output hreadyout, hresp
    );

    modport mux (input hreadyout, hresp);

endinterface

// ==== hdl/ahb_default_slave.sv ====
//------------------------------------------------
// Error responder for unmapped addresses
// NONSEQ/SEQ get a two-cycle ERROR, IDLE/BUSY get OKAY
// The ERROR wait cycle always advances, other states
// hold while hready is low
//------------------------------------------------
`timescale 1ns/100ps

module ahb_default_slave
    import ahb_pkg::*;
(
    input  logic         HCLK,
    input  logic         HRESETn,
    dft_slave_if.slave   dft
);

    typedef enum logic [1:0] {
        DS_IDLE,   // OKAY, ready
        DS_ERR1,   // ERROR, wait state
        DS_ERR2    // ERROR, ready
    } ds_state_t;

    ds_state_t state;
    ds_state_t state_nxt;
    logic      trans_req;   // Active transfer sampled this edge

    // Only NONSEQ and SEQ need an error response
    assign trans_req = dft.hsel && dft.hready &&
                       ((dft.htrans == NONSEQ) || (dft.htrans == SEQ));

    //------------------------------------------------
    // Next state
    //------------------------------------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            DS_ERR1:
                state_nxt = DS_ERR2;   // Own wait state, never stalls
            DS_IDLE, DS_ERR2:
            begin
                if (dft.hready)
                    state_nxt = trans_req ? DS_ERR1 : DS_IDLE;
            end
        endcase
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            state <= DS_IDLE;
        else
            state <= state_nxt;
    end

    // Outputs straight from state
    assign dft.hreadyout = (state != DS_ERR1);
    assign dft.hresp     = (state == DS_IDLE) ? OKAY : ERROR;

endmodule

// ==== hdl/ahb_addr_decoder.sv ====
//------------------------------------------------
// Address phase decode for one matrix input
// Fully combinational, lowest matching port wins
// IDLE stays on the current data-phase port
//------------------------------------------------
`timescale 1ns/100ps

module ahb_addr_decoder
    import ahb_pkg::*;
    import matrix_pkg::*;
(
    input  dec_addr_t             decode_addr,  // HADDR[31:10]
    input  htrans_t               htrans,
    input  logic                  hsel,         // Select from the input stage
    input  out_port_t             data_port,    // Current data-phase owner
    input  logic [NUM_PORTS-1:0]  active_in,    // Per-port active flags
    output logic [NUM_PORTS-1:0]  sel,          // One-hot port selects
    output logic                  active,
    output out_port_t             addr_port,    // Address-phase owner
    dft_slave_if.decoder          dft
);

    logic [NUM_PORTS-1:0] hit;   // Region match or IDLE stick, per port

    //------------------------------------------------
    // Region compare
    //------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            hit[i] = ((decode_addr >= REGION_LO[i]) && (decode_addr <= REGION_HI[i]))
                     || ((data_port == port_of(i)) && (htrans == IDLE));
        end
    end

    // Scan from the top so MI0 is written last and wins
    always_comb
    begin
        addr_port = PORT_DFT;   // Nothing matched
        for (int i = NUM_PORTS - 1; i >= 0; i--)
        begin
            if (hit[i])
                addr_port = port_of(i);
        end
    end

    //------------------------------------------------
    // Selects and active flag
    //------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            sel[i] = hsel && (addr_port == port_of(i));
        end
    end

    assign dft.hsel = hsel && (addr_port == PORT_DFT);

    // Default slave is always ready to take a transfer
    always_comb
    begin
        active = 1'b1;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (addr_port == port_of(i))
                active = active_in[i];
        end
    end

endmodule

// ==== hdl/ahb_data_phase_mux.sv ====
//------------------------------------------------
// Data phase owner register and response steering
// Owner loads on every hreadys, resets to MI0
// Default slave returns zero read data
//------------------------------------------------
`timescale 1ns/100ps

module ahb_data_phase_mux
    import ahb_pkg::*;
    import matrix_pkg::*;
(
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  logic                  hreadys,                 // Input port transfer done
    input  out_port_t             addr_port,               // From address decode
    input  logic [NUM_PORTS-1:0]  readyout_in,
    input  hresp_t                resp_in  [NUM_PORTS],
    input  hrdata_t               rdata_in [NUM_PORTS],
    output out_port_t             data_port,
    output logic                  hreadyout,
    output hresp_t                hresp,
    output hrdata_t               hrdata,
    dft_slave_if.mux              dft
);

    //------------------------------------------------
    // Data phase port
    //------------------------------------------------
    // hreadys, not the muxed readyout, marks the address phase end
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            data_port <= PORT_MI0;
        else if (hreadys)
            data_port <= addr_port;
    end

    // Response steering from the owner
    always_comb
    begin
        hreadyout = dft.hreadyout;   // Default slave unless a port matches
        hresp     = dft.hresp;
        hrdata    = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (data_port == port_of(i))
            begin
                hreadyout = readyout_in[i];
                hresp     = resp_in[i];
                hrdata    = rdata_in[i];
            end
        end
    end

endmodule

// ==== hdl/ahb_decoder_stage.sv ====
//------------------------------------------------
// Decoder stage of one AHB matrix input, MI0 to MI3
// Unmapped addresses go to a local error slave
// Selects and active are combinational from the inputs
//------------------------------------------------
`timescale 1ns/100ps

module ahb_decoder_stage
    import ahb_pkg::*;
    import matrix_pkg::*;
(
    input  logic       HCLK,
    input  logic       HRESETn,

    // From the input stage
    input  logic       hreadys,       // Transfer done
    input  logic       hsel,
    input  dec_addr_t  decode_addr,   // HADDR[31:10]
    input  htrans_t    htrans,

    // Output port MI0
    input  logic       active_0,
    input  logic       readyout_0,
    input  hresp_t     resp_0,
    input  hrdata_t    rdata_0,

    // Output port MI1
    input  logic       active_1,
    input  logic       readyout_1,
    input  hresp_t     resp_1,
    input  hrdata_t    rdata_1,

    // Output port MI2
    input  logic       active_2,
    input  logic       readyout_2,
    input  hresp_t     resp_2,
    input  hrdata_t    rdata_2,

    // Output port MI3
    input  logic       active_3,
    input  logic       readyout_3,
    input  hresp_t     resp_3,
    input  hrdata_t    rdata_3,

    output logic       sel_0,
    output logic       sel_1,
    output logic       sel_2,
    output logic       sel_3,

    // Back to the input stage
    output logic       active,
    output logic       hreadyout,
    output hresp_t     hresp,
    output hrdata_t    hrdata
);

    logic [NUM_PORTS-1:0] sel_vec;
    logic [NUM_PORTS-1:0] active_vec;
    logic [NUM_PORTS-1:0] readyout_vec;
    hresp_t               resp_arr  [NUM_PORTS];
    hrdata_t              rdata_arr [NUM_PORTS];
    out_port_t            addr_port;   // Address phase owner
    out_port_t            data_port;   // Data phase owner

    //------------------------------------------------
    // Port packing
    //------------------------------------------------
    assign active_vec   = {active_3, active_2, active_1, active_0};
    assign readyout_vec = {readyout_3, readyout_2, readyout_1, readyout_0};
    assign resp_arr     = '{resp_0, resp_1, resp_2, resp_3};
    assign rdata_arr    = '{rdata_0, rdata_1, rdata_2, rdata_3};

    assign {sel_3, sel_2, sel_1, sel_0} = sel_vec;

    dft_slave_if u_dft_if ();

    assign u_dft_if.htrans = htrans;    // Default slave sees the raw transfer
    assign u_dft_if.hready = hreadys;

    ahb_addr_decoder u_addr_decoder (
        .decode_addr (decode_addr),
        .htrans      (htrans),
        .hsel        (hsel),
        .data_port   (data_port),
        .active_in   (active_vec),
        .sel         (sel_vec),
        .active      (active),
        .addr_port   (addr_port),
        .dft         (u_dft_if.decoder)
    );

    ahb_data_phase_mux u_data_mux (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .hreadys     (hreadys),
        .addr_port   (addr_port),
        .readyout_in (readyout_vec),
        .resp_in     (resp_arr),
        .rdata_in    (rdata_arr),
        .data_port   (data_port),
        .hreadyout   (hreadyout),
        .hresp       (hresp),
        .hrdata      (hrdata),
        .dft         (u_dft_if.mux)
    );

    ahb_default_slave u_default_slave (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .dft     (u_dft_if.slave)
    );

endmodule

// ==== dv/decoder_stage_assertions.sv ====
//------------------------------------------------
// Concurrent checks bound into the decoder stage
// Default slave signals are taken from the stage link
//------------------------------------------------
`timescale 1ns/100ps

module decoder_stage_assertions
    import ahb_pkg::*;
(
    input logic   HCLK,
    input logic   HRESETn,
    input logic   hsel,            // Select from the input stage
    input logic   sel_0,
    input logic   sel_1,
    input logic   sel_2,
    input logic   sel_3,
    input logic   dft_hsel,        // Default slave select
    input logic   dft_hreadyout,
    input hresp_t dft_hresp
);

    logic [4:0] all_sel;   // Four ports plus default slave

    assign all_sel = {dft_hsel, sel_3, sel_2, sel_1, sel_0};

    // One owner per address phase
    a_sel_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $onehot0(all_sel))
        else $error("more than one select high");

    a_sel_needs_hsel: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !hsel |-> (all_sel == 5'b00000))
        else $error("select high without hsel");

    // ERROR wait state is always followed by the ready ERROR cycle
    a_err_pair: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (!dft_hreadyout && (dft_hresp == ERROR)) |=> (dft_hreadyout && (dft_hresp == ERROR)))
        else $error("default slave error response not two cycles");

endmodule

// ==== dv/tb_decoder_stage.sv ====
//------------------------------------------------
// Random testbench for the decoder stage, fixed LFSR seed
// Port slaves are random levels with tagged read data
// Stops at the first mismatch against the model
//------------------------------------------------
`timescale 1ns/100ps

module tb_decoder_stage
    import ahb_pkg::*;
    import matrix_pkg::*;
();

    localparam int NUM_CYCLES  = 3000;
    localparam int WATCHDOG_NS = (NUM_CYCLES + 10) * 4 + 200;   // Loop, reset, margin

    // Model of the default slave
    typedef enum logic [1:0] {
        DFT_IDLE,
        DFT_WAIT,   // ERROR, not ready
        DFT_LAST    // ERROR, ready
    } dft_model_t;

    logic                 HCLK = 1'b0;
    logic                 HRESETn;
    logic                 hreadys;
    logic                 hsel;
    dec_addr_t            decode_addr;
    htrans_t              htrans;
    logic [NUM_PORTS-1:0] act;              // Per-port active
    logic [NUM_PORTS-1:0] rdy;              // Per-port readyout
    hresp_t               rsp [NUM_PORTS];
    hrdata_t              tag [NUM_PORTS];  // Read data tagged with port number
    logic [NUM_PORTS-1:0] sel;
    logic                 active;
    logic                 hreadyout;
    hresp_t               hresp;
    hrdata_t              hrdata;

    logic [31:0] lfsr = 32'h8eb7;
    out_port_t   m_dport;   // Model data phase owner
    dft_model_t  m_dft;
    int          n_stick;   // IDLE stick cases seen
    int          n_err;     // Error transfers to the default slave

    always #2 HCLK = ~HCLK;   // 4 ns period

    ahb_decoder_stage UUT (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .hreadys     (hreadys),
        .hsel        (hsel),
        .decode_addr (decode_addr),
        .htrans      (htrans),
        .active_0    (act[0]),
        .readyout_0  (rdy[0]),
        .resp_0      (rsp[0]),
        .rdata_0     (tag[0]),
        .active_1    (act[1]),
        .readyout_1  (rdy[1]),
        .resp_1      (rsp[1]),
        .rdata_1     (tag[1]),
        .active_2    (act[2]),
        .readyout_2  (rdy[2]),
        .resp_2      (rsp[2]),
        .rdata_2     (tag[2]),
        .active_3    (act[3]),
        .readyout_3  (rdy[3]),
        .resp_3      (rsp[3]),
        .rdata_3     (tag[3]),
        .sel_0       (sel[0]),
        .sel_1       (sel[1]),
        .sel_2       (sel[2]),
        .sel_3       (sel[3]),
        .active      (active),
        .hreadyout   (hreadyout),
        .hresp       (hresp),
        .hrdata      (hrdata)
    );

    bind ahb_decoder_stage decoder_stage_assertions u_assertions (
        .HCLK          (HCLK),
        .HRESETn       (HRESETn),
        .hsel          (hsel),
        .sel_0         (sel_0),
        .sel_1         (sel_1),
        .sel_2         (sel_2),
        .sel_3         (sel_3),
        .dft_hsel      (u_dft_if.hsel),
        .dft_hreadyout (u_dft_if.hreadyout),
        .dft_hresp     (u_dft_if.hresp)
    );

    //------------------------------------------------
    // Random source and reference model
    //------------------------------------------------
    // Galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // First region hit wins, IDLE sticks to the data phase owner
    function automatic out_port_t expect_port(input dec_addr_t a, input htrans_t t,
                                              input out_port_t owner);
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (((a >= REGION_LO[i]) && (a <= REGION_HI[i]))
                || ((t == IDLE) && (owner == out_port_t'(3'(i)))))
                return out_port_t'(3'(i));
        end
        return PORT_DFT;
    endfunction

    //------------------------------------------------
    // Failure reporting and compare tasks
    //------------------------------------------------
    task automatic stop_failed();
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input string got, input string exp);
        $display("[FAIL] %0t ns %s got %s expected %s", $time, name, got, exp);
        stop_failed();
    endtask

    task automatic check_port(input string name, input out_port_t got, input out_port_t exp);
        if (got !== exp)
            report_mismatch(name, got.name(), exp.name());
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_resp(input string name, input hresp_t got, input hresp_t exp);
        if (got !== exp)
            report_mismatch(name, got.name(), exp.name());
    endtask

    task automatic check_data(input string name, input hrdata_t got, input hrdata_t exp);
        if (got !== exp)
            report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    //------------------------------------------------
    // Per-cycle stimulus, checks and model update
    //------------------------------------------------
    task automatic drive_random();
        logic [31:0] r;
        logic [1:0]  k;
        r = take_bits(3);
        k = r[1:0];
        if (r[2])
            decode_addr = REGION_HI[k] + 22'd1;   // Just above a region, unmapped
        else
        begin
            r           = take_bits(10);
            decode_addr = REGION_LO[k]
                          + (dec_addr_t'(r[9:0]) % (REGION_HI[k] - REGION_LO[k] + 22'd1));
        end
        r       = take_bits(5);
        htrans  = htrans_t'(r[1:0]);
        hsel    = r[2];
        hreadys = (r[4:3] != 2'b00);   // Mostly high
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            r      = take_bits(3);
            act[i] = r[0];
            rdy[i] = r[1];
            rsp[i] = r[2] ? ERROR : OKAY;
        end
    endtask

    task automatic check_outputs();
        out_port_t exp_port;
        out_port_t got_port;
        exp_port = expect_port(decode_addr, htrans, m_dport);
        if ($countones(sel) > 1)
        begin
            $display("More than one port select is high at %0t ns", $time);
            stop_failed();
        end
        got_port = PORT_DFT;   // No port select seen
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (sel[i])
                got_port = out_port_t'(3'(i));
        end
        check_port("sel_n", got_port, hsel ? exp_port : PORT_DFT);
        check_bit("active", active, (exp_port == PORT_DFT) ? 1'b1 : act[exp_port[1:0]]);
        if (m_dport == PORT_DFT)
        begin
            check_bit("hreadyout", hreadyout, m_dft != DFT_WAIT);
            check_resp("hresp", hresp, (m_dft == DFT_IDLE) ? OKAY : ERROR);
            check_data("hrdata", hrdata, '0);
        end
        else
        begin
            check_bit("hreadyout", hreadyout, rdy[m_dport[1:0]]);
            check_resp("hresp", hresp, rsp[m_dport[1:0]]);
            check_data("hrdata", hrdata, tag[m_dport[1:0]]);
        end
    endtask

    task automatic update_model();
        out_port_t nxt;
        logic      err_req;
        nxt     = expect_port(decode_addr, htrans, m_dport);
        err_req = hsel && hreadys && (nxt == PORT_DFT)
                  && ((htrans == NONSEQ) || (htrans == SEQ));
        // Unmapped IDLE kept on a real port
        if (hsel && (htrans == IDLE) && (m_dport != PORT_DFT)
            && (expect_port(decode_addr, BUSY, m_dport) == PORT_DFT))
            n_stick++;
        if (err_req)
            n_err++;
        if (m_dft == DFT_WAIT)
            m_dft = DFT_LAST;   // Wait state always advances
        else if (hreadys)
            m_dft = err_req ? DFT_WAIT : DFT_IDLE;
        if (hreadys)
            m_dport = nxt;
    endtask

    //------------------------------------------------
    // Main sequence
    //------------------------------------------------
    initial
    begin
        HRESETn     = 1'b0;
        hreadys     = 1'b1;
        hsel        = 1'b0;
        decode_addr = '0;
        htrans      = IDLE;
        act         = '0;
        rdy         = '1;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            rsp[i] = OKAY;
            tag[i] = 32'hda7a_0000 | 32'(i);
        end
        m_dport = PORT_MI0;   // Reset owner
        m_dft   = DFT_IDLE;
        n_stick = 0;
        n_err   = 0;
        repeat (4) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;
        for (int c = 0; c < NUM_CYCLES; c++)
        begin
            drive_random();
            #1;
            check_outputs();
            @(posedge HCLK);
            update_model();
            @(negedge HCLK);
        end
        if ((n_stick == 0) || (n_err == 0))
        begin
            $display("Stimulus never reached the IDLE stick or the error response case");
            stop_failed();
        end
        else
        begin
            $display("All tests passed!");
            $finish;
        end
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all cycles were checked");
        stop_failed();
    end

endmodule

// ==== all.f ====
hdl/ahb_pkg.sv
hdl/matrix_pkg.sv
hdl/dft_slave_if.sv
hdl/ahb_default_slave.sv
hdl/ahb_addr_decoder.sv
hdl/ahb_data_phase_mux.sv
hdl/ahb_decoder_stage.sv
dv/decoder_stage_assertions.sv
dv/tb_decoder_stage.sv

// ==== Makefile ====
TOP := tb_decoder_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f all.f --top-module ahb_decoder_stage

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
